// File: Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: src.f
src/icache_pkg.sv
src/icache_req_decode.sv
src/icache_tagv_array.sv
src/icache_data_array.sv
src/icache_way_lru.sv
src/icache_refill_fsm.sv
src/icache_result_mux.sv
src/icache_top.sv
testbench/icache_mem_model.sv
testbench/icache_tb.sv

// File: src/icache_data_array.sv
`timescale 1ns/1ps

module icache_data_array #(
    parameter int SETS = 64
) (
    input  logic                        clk,
    input  logic [$clog2(SETS)-1:0]     rd_index,
    input  logic                        wr_en,
    input  icache_pkg::way_mask_t       wr_way,
    input  logic [$clog2(SETS)-1:0]     wr_index,
    input  icache_pkg::line_t           wr_line,
    output icache_pkg::line_t [3:0]     rd_lines
);
    import icache_pkg::*;

    line_t mem [4][SETS];

    // whole-line writes only, no word enables
    always_ff @(posedge clk) begin
        for (int w = 0; w < 4; w++) begin
            if (wr_en && wr_way[w]) begin
                mem[w][wr_index] <= wr_line;
            end
            rd_lines[w] <= mem[w][rd_index];
        end
    end

endmodule

// File: src/icache_pkg.sv
package icache_pkg;

    localparam int LINE_WORDS = 16;                  // 64-byte line

    typedef logic [31:0] addr_t;
    typedef logic [63:0] fetch_t;                    // two instruction words
    typedef logic [31:0] word_t;
    typedef logic [19:0] tag_t;                      // addr[31:12]
    typedef logic [3:0]  way_mask_t;                 // one-hot way
    typedef logic [6:0]  exc_t;
    typedef logic [1:0]  cacop_t;
    typedef logic [LINE_WORDS*32-1:0] line_t;

    localparam exc_t EXC_NONE = 7'h00;
    localparam exc_t EXC_ADEF = 7'h08;               // misaligned fetch

    localparam cacop_t CACOP_INDEX_INV = 2'd1;       // way from addr[1:0]
    localparam cacop_t CACOP_HIT_INV   = 2'd2;       // way that hits

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        REFILL,
        RESPOND,
        CACOP
    } fill_state_t;

endpackage

// File: src/icache_refill_fsm.sv
`timescale 1ns/1ps

module icache_refill_fsm #(
    parameter int SETS = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      valid,
    input  logic                      cacop_en,
    input  logic                      flush,
    input  logic                      req_uncache,
    input  logic                      req_cacop,
    input  icache_pkg::cacop_t        req_cacop_code,
    input  icache_pkg::exc_t          req_exc,
    input  icache_pkg::addr_t         req_paddr,
    input  logic                      hit,
    input  icache_pkg::way_mask_t     hit_way,
    input  icache_pkg::way_mask_t     victim,
    input  logic                      r_rdy,
    input  logic                      ret_valid,
    input  logic                      ret_last,
    input  icache_pkg::word_t         r_data_axi,
    output logic                      cache_ready,
    output logic                      accept,
    output logic                      r_req,
    output icache_pkg::addr_t         r_addr,
    output logic [7:0]                r_length,
    output logic                      tag_wr_en,
    output logic                      data_wr_en,
    output icache_pkg::way_mask_t     fill_way,
    output icache_pkg::line_t         fill_line,
    output logic                      inv_en,
    output icache_pkg::way_mask_t     inv_way,
    output logic                      clear_en,
    output logic [$clog2(SETS)-1:0]   clear_index,
    output logic                      lru_touch,
    output icache_pkg::way_mask_t     touch_way,
    output logic                      sel_fill,
    output logic                      data_valid,
    output logic                      cacop_complete
);
    import icache_pkg::*;

    localparam int IDX_W = $clog2(SETS);

    fill_state_t      state;
    fill_state_t      state_next;
    word_t            line_buf [LINE_WORDS];
    logic [3:0]       beat_cnt;
    logic [IDX_W-1:0] sweep_cnt;
    logic             sweep_busy;
    logic             kill;                          // response flushed
    logic             fetch_done;
    logic             need_mem;
    logic             hit_touch;
    logic             last_beat;
    logic             fill_wr;

    assign fetch_done = (state == LOOKUP) && !req_cacop &&
                        ((req_exc != EXC_NONE) || (!req_uncache && hit));
    assign need_mem   = (state == LOOKUP) && !req_cacop && (req_exc == EXC_NONE) &&
                        (req_uncache || !hit);
    assign hit_touch  = fetch_done && (req_exc == EXC_NONE);
    assign last_beat  = (state == REFILL) && ret_valid && ret_last;
    assign fill_wr    = last_beat && !req_uncache;  // uncached data never allocates

    always_comb begin
        case (state)
            IDLE:          cache_ready = !sweep_busy;
            LOOKUP:        cache_ready = fetch_done;
            RESPOND, CACOP: cache_ready = 1'b1;
            default:       cache_ready = 1'b0;
        endcase
    end

    assign accept = (valid || cacop_en) && cache_ready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:     if (accept) state_next = LOOKUP;
            LOOKUP: begin
                if (req_cacop) begin
                    state_next = CACOP;
                end else if (need_mem) begin
                    state_next = r_rdy ? REFILL : MISS_REQ;
                end else begin
                    state_next = accept ? LOOKUP : IDLE;
                end
            end
            MISS_REQ: if (r_rdy) state_next = REFILL;
            REFILL:   if (last_beat) state_next = RESPOND;
            RESPOND, CACOP: state_next = accept ? LOOKUP : IDLE;
            default:  state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            sweep_busy <= 1'b1;
            sweep_cnt  <= '0;
            kill       <= 1'b0;
        end else begin
            state <= state_next;
            if (sweep_busy) begin
                sweep_cnt <= sweep_cnt + 1'b1;
                if (sweep_cnt == IDX_W'(SETS - 1)) begin
                    sweep_busy <= 1'b0;
                end
            end
            if (flush) begin
                kill <= 1'b1;
            end else if (accept) begin
                kill <= 1'b0;
            end
        end
    end

    // uncached words land at their own pair slot so the result mux needs no extra path
    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            fill_way <= victim;
        end
        if (state != REFILL) begin
            beat_cnt <= req_uncache ? {req_paddr[5:3], 1'b0} : 4'd0;
        end else if (ret_valid) begin
            line_buf[beat_cnt] <= r_data_axi;
            beat_cnt           <= beat_cnt + 4'd1;
        end
    end

    // last beat merged in so the line is written on the ret_last cycle
    always_comb begin
        for (int i = 0; i < LINE_WORDS; i++) begin
            fill_line[i*32 +: 32] = ((state == REFILL) && ret_valid && (beat_cnt == 4'(i))) ?
                                    r_data_axi : line_buf[i];
        end
    end

    assign r_req    = need_mem || (state == MISS_REQ);
    assign r_addr   = req_uncache ? {req_paddr[31:3], 3'b000} : {req_paddr[31:6], 6'b000000};
    assign r_length = req_uncache ? 8'd1 : 8'd15;

    assign tag_wr_en  = fill_wr;
    assign data_wr_en = fill_wr;

    assign inv_en  = (state == LOOKUP) && req_cacop &&
                     ((req_cacop_code == CACOP_INDEX_INV) ||
                      ((req_cacop_code == CACOP_HIT_INV) && hit));
    assign inv_way = (req_cacop_code == CACOP_HIT_INV) ? hit_way :
                     way_mask_t'(4'b0001 << req_paddr[1:0]);

    assign clear_en    = sweep_busy;
    assign clear_index = sweep_cnt;

    assign lru_touch = hit_touch || fill_wr;
    assign touch_way = fill_wr ? fill_way : hit_way;

    assign sel_fill       = (state == RESPOND);
    assign data_valid     = (fetch_done || (state == RESPOND)) && !kill && !flush;
    assign cacop_complete = (state == CACOP);

    assert property (@(posedge clk) disable iff (!rst_n) r_req && !r_rdy |=> r_req)
        else $error("r_req dropped before r_rdy");

    // the core issues either a fetch or a cache operation in one cycle
    assert property (@(posedge clk) disable iff (!rst_n) accept |-> !(valid && cacop_en))
        else $error("fetch and cache operation accepted together");

endmodule

// File: src/icache_req_decode.sv
`timescale 1ns/1ps

module icache_req_decode #(
    parameter int SETS = 64
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    accept,
    input  icache_pkg::addr_t       pc_in,
    input  icache_pkg::addr_t       p_addr,
    input  logic                    uncache,
    input  logic                    cacop_en,
    input  icache_pkg::cacop_t      cacop_code,
    input  icache_pkg::exc_t        tlb_exception,
    output icache_pkg::addr_t       req_pc,
    output icache_pkg::addr_t       req_paddr,
    output logic                    req_uncache,
    output logic                    req_cacop,
    output icache_pkg::cacop_t      req_cacop_code,
    output icache_pkg::exc_t        req_exc,
    output logic [$clog2(SETS)-1:0] req_index,
    output icache_pkg::tag_t        req_tag,
    output logic [2:0]              req_word
);
    import icache_pkg::*;

    localparam int IDX_W = $clog2(SETS);

    exc_t exc_next;

    // address error wins over the translation result
    assign exc_next = cacop_en              ? EXC_NONE :
                      (pc_in[1:0] != 2'b00) ? EXC_ADEF : tlb_exception;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_uncache <= 1'b0;
            req_cacop   <= 1'b0;
        end else if (accept) begin
            req_uncache <= uncache && !cacop_en;
            req_cacop   <= cacop_en;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_pc         <= pc_in;
            req_paddr      <= p_addr;
            req_cacop_code <= cacop_code;
            req_exc        <= exc_next;
        end
    end

    assign req_tag   = req_paddr[31:12];
    assign req_index = req_paddr[6 +: IDX_W];
    assign req_word  = req_paddr[5:3];              // pair within the line

endmodule

// File: src/icache_result_mux.sv
`timescale 1ns/1ps

module icache_result_mux (
    input  icache_pkg::line_t [3:0]   rd_lines,
    input  icache_pkg::way_mask_t     hit_way,
    input  icache_pkg::line_t         fill_line,
    input  logic                      sel_fill,
    input  logic [2:0]                req_word,
    input  icache_pkg::addr_t         req_pc,
    input  icache_pkg::exc_t          req_exc,
    output icache_pkg::fetch_t        r_data,
    output icache_pkg::exc_t          exception,
    output icache_pkg::addr_t         badv
);
    import icache_pkg::*;

    line_t line;

    always_comb begin
        line = '0;
        if (sel_fill) begin
            line = fill_line;
        end else begin
            for (int w = 0; w < 4; w++) begin
                if (hit_way[w]) begin
                    line = line | rd_lines[w];       // one-hot and-or select
                end
            end
        end
    end

    assign r_data    = line[{req_word, 6'd0} +: 64];
    assign exception = req_exc;
    assign badv      = (req_exc != EXC_NONE) ? req_pc : '0;

endmodule

// File: src/icache_tagv_array.sv
`timescale 1ns/1ps

module icache_tagv_array #(
    parameter int SETS = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [$clog2(SETS)-1:0]   rd_index,
    input  icache_pkg::tag_t          cmp_tag,
    input  logic                      wr_en,
    input  icache_pkg::way_mask_t     wr_way,
    input  logic [$clog2(SETS)-1:0]   wr_index,
    input  icache_pkg::tag_t          wr_tag,
    input  logic                      inv_en,
    input  icache_pkg::way_mask_t     inv_way,
    input  logic [$clog2(SETS)-1:0]   clear_index,
    input  logic                      clear_en,
    output icache_pkg::way_mask_t     hit_way,
    output logic                      hit
);
    import icache_pkg::*;

    tag_t        tag_mem [4][SETS];
    logic [SETS-1:0] valid_mem [4];
    tag_t        rd_tag [4];
    way_mask_t   rd_valid;

    always_ff @(posedge clk) begin
        for (int w = 0; w < 4; w++) begin
            if (wr_en && wr_way[w]) begin
                tag_mem[w][wr_index] <= wr_tag;
            end
            rd_tag[w] <= tag_mem[w][rd_index];
        end
    end

    // sweep clear first, then invalidate, then fill
    always_ff @(posedge clk) begin
        for (int w = 0; w < 4; w++) begin
            if (clear_en) begin
                valid_mem[w][clear_index] <= 1'b0;
            end else if (inv_en && inv_way[w]) begin
                valid_mem[w][wr_index] <= 1'b0;
            end else if (wr_en && wr_way[w]) begin
                valid_mem[w][wr_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= '0;
        end else begin
            for (int w = 0; w < 4; w++) begin
                rd_valid[w] <= valid_mem[w][rd_index];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < 4; w++) begin
            hit_way[w] = rd_valid[w] && (rd_tag[w] == cmp_tag);
        end
    end

    assign hit = |hit_way;

    // a line is never allocated in two ways of one set
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(hit_way))
        else $error("tag hit in more than one way");

endmodule

// File: src/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
    parameter int SETS = 64
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid,
    input  logic                   flush,
    input  icache_pkg::addr_t      pc_in,
    input  icache_pkg::addr_t      p_addr,
    input  logic                   uncache,
    input  icache_pkg::exc_t       tlb_exception,
    input  logic                   cacop_en,
    input  icache_pkg::cacop_t     cacop_code,
    output logic                   cache_ready,
    output logic                   data_valid,
    output logic                   cacop_complete,
    output icache_pkg::fetch_t     r_data,
    output icache_pkg::addr_t      pc_out,
    output icache_pkg::exc_t       exception,
    output icache_pkg::addr_t      badv,
    output logic                   r_req,
    output icache_pkg::addr_t      r_addr,
    output logic [7:0]             r_length,
    input  logic                   r_rdy,
    input  logic                   ret_valid,
    input  logic                   ret_last,
    input  icache_pkg::word_t      r_data_axi
);
    import icache_pkg::*;

    localparam int IDX_W = $clog2(SETS);

    logic             accept;
    addr_t            req_pc;
    addr_t            req_paddr;
    logic             req_uncache;
    logic             req_cacop;
    cacop_t           req_cacop_code;
    exc_t             req_exc;
    logic [IDX_W-1:0] req_index;
    logic [IDX_W-1:0] lookup_index;
    tag_t             req_tag;
    logic [2:0]       req_word;
    way_mask_t        hit_way;
    logic             hit;
    way_mask_t        victim;
    line_t [3:0]      rd_lines;
    logic             tag_wr_en;
    logic             data_wr_en;
    way_mask_t        fill_way;
    line_t            fill_line;
    logic             inv_en;
    way_mask_t        inv_way;
    logic             clear_en;
    logic [IDX_W-1:0] clear_index;
    logic             lru_touch;
    way_mask_t        touch_way;
    logic             sel_fill;

    // arrays are read with the incoming index so a hit answers next cycle
    assign lookup_index = accept ? p_addr[6 +: IDX_W] : req_index;
    assign pc_out       = req_pc;

    icache_req_decode #(.SETS(SETS)) u_req_decode (
        .clk(clk), .rst_n(rst_n), .accept(accept),
        .pc_in(pc_in), .p_addr(p_addr), .uncache(uncache),
        .cacop_en(cacop_en), .cacop_code(cacop_code), .tlb_exception(tlb_exception),
        .req_pc(req_pc), .req_paddr(req_paddr), .req_uncache(req_uncache),
        .req_cacop(req_cacop), .req_cacop_code(req_cacop_code), .req_exc(req_exc),
        .req_index(req_index), .req_tag(req_tag), .req_word(req_word)
    );

    icache_tagv_array #(.SETS(SETS)) u_tagv_array (
        .clk(clk), .rst_n(rst_n), .rd_index(lookup_index), .cmp_tag(req_tag),
        .wr_en(tag_wr_en), .wr_way(fill_way), .wr_index(req_index), .wr_tag(req_tag),
        .inv_en(inv_en), .inv_way(inv_way),
        .clear_index(clear_index), .clear_en(clear_en),
        .hit_way(hit_way), .hit(hit)
    );

    icache_data_array #(.SETS(SETS)) u_data_array (
        .clk(clk), .rd_index(lookup_index),
        .wr_en(data_wr_en), .wr_way(fill_way), .wr_index(req_index),
        .wr_line(fill_line), .rd_lines(rd_lines)
    );

    icache_way_lru #(.SETS(SETS)) u_way_lru (
        .clk(clk), .rst_n(rst_n), .index(req_index),
        .touch_en(lru_touch), .touch_way(touch_way), .victim(victim)
    );

    icache_refill_fsm #(.SETS(SETS)) u_refill_fsm (
        .clk(clk), .rst_n(rst_n), .valid(valid), .cacop_en(cacop_en), .flush(flush),
        .req_uncache(req_uncache), .req_cacop(req_cacop), .req_cacop_code(req_cacop_code),
        .req_exc(req_exc), .req_paddr(req_paddr),
        .hit(hit), .hit_way(hit_way), .victim(victim),
        .r_rdy(r_rdy), .ret_valid(ret_valid), .ret_last(ret_last), .r_data_axi(r_data_axi),
        .cache_ready(cache_ready), .accept(accept),
        .r_req(r_req), .r_addr(r_addr), .r_length(r_length),
        .tag_wr_en(tag_wr_en), .data_wr_en(data_wr_en),
        .fill_way(fill_way), .fill_line(fill_line),
        .inv_en(inv_en), .inv_way(inv_way),
        .clear_en(clear_en), .clear_index(clear_index),
        .lru_touch(lru_touch), .touch_way(touch_way), .sel_fill(sel_fill),
        .data_valid(data_valid), .cacop_complete(cacop_complete)
    );

    icache_result_mux u_result_mux (
        .rd_lines(rd_lines), .hit_way(hit_way), .fill_line(fill_line),
        .sel_fill(sel_fill), .req_word(req_word), .req_pc(req_pc), .req_exc(req_exc),
        .r_data(r_data), .exception(exception), .badv(badv)
    );

endmodule

// File: src/icache_way_lru.sv
`timescale 1ns/1ps

module icache_way_lru #(
    parameter int SETS = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [$clog2(SETS)-1:0]   index,
    input  logic                      touch_en,
    input  icache_pkg::way_mask_t     touch_way,
    output icache_pkg::way_mask_t     victim
);

    // bit 0 picks the half to evict from, bit 1 ways 0/1, bit 2 ways 2/3
    logic [2:0] tree [SETS];
    logic [2:0] cur;
    logic [2:0] upd;

    assign cur = tree[index];

    always_comb begin
        upd = cur;
        if (touch_way[0] || touch_way[1]) begin
            upd[0] = 1'b1;                           // evict from upper half next
            upd[1] = touch_way[0];
        end else begin
            upd[0] = 1'b0;
            upd[2] = touch_way[2];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                tree[s] <= 3'b000;
            end
        end else if (touch_en) begin
            tree[index] <= upd;
        end
    end

    always_comb begin
        victim = '0;
        if (cur[0]) begin
            victim[cur[2] ? 3 : 2] = 1'b1;
        end else begin
            victim[cur[1] ? 1 : 0] = 1'b1;
        end
    end

endmodule

// File: testbench/icache_mem_model.sv
`timescale 1ns/1ps

module icache_mem_model #(
    parameter logic [15:0] SEED = 16'd11878
) (
    input  logic                  clk,
    input  logic                  r_req,
    input  icache_pkg::addr_t     r_addr,
    input  logic [7:0]            r_length,
    output logic                  r_rdy,
    output logic                  ret_valid,
    output logic                  ret_last,
    output icache_pkg::word_t     r_data_axi
);
    import icache_pkg::*;

    localparam word_t MEM_MARK = 32'h5A5A_0000;      // word = byte address ^ mark

    logic [15:0] lfsr;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr  = lfsr_next(lfsr);                 // one step per bit
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    initial begin
        addr_t base;
        int    len;
        int    gap;
        lfsr       = SEED;
        r_rdy      = 1'b0;
        ret_valid  = 1'b0;
        ret_last   = 1'b0;
        r_data_axi = '0;
        forever begin
            @(negedge clk);
            if (r_req) begin
                base = r_addr;
                len  = int'(r_length);
                draw_bits(2, gap);                   // 0 to 3 cycles before the grant
                repeat (gap) @(posedge clk);
                @(posedge clk);
                #2;
                r_rdy = 1'b1;
                @(posedge clk);
                #2;
                r_rdy = 1'b0;
                for (int i = 0; i <= len; i++) begin
                    draw_bits(2, gap);
                    repeat (gap % 3) begin           // idle beats
                        @(posedge clk);
                        #2;
                    end
                    ret_valid  = 1'b1;
                    ret_last   = (i == len);
                    r_data_axi = (base + addr_t'(4 * i)) ^ MEM_MARK;
                    @(posedge clk);
                    #2;
                    ret_valid  = 1'b0;
                    ret_last   = 1'b0;
                end
            end
        end
    end

endmodule

// File: testbench/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;
    import icache_pkg::*;

    localparam int    SETS           = 64;
    localparam int    NUM_REQ        = 29;
    localparam int    TIMEOUT_CYCLES = 400 * NUM_REQ;
    localparam word_t MEM_MARK       = 32'h5A5A_0000;
    localparam addr_t SET8_BASE      = 32'h0007_0200; // tags 0x70..0x74 all land in set 8

    logic       clk;
    logic       rst_n;
    logic       valid;
    logic       flush;
    addr_t      pc_in;
    addr_t      p_addr;
    logic       uncache;
    exc_t       tlb_exception;
    logic       cacop_en;
    cacop_t     cacop_code;
    logic       cache_ready;
    logic       data_valid;
    logic       cacop_complete;
    fetch_t     r_data;
    addr_t      pc_out;
    exc_t       exception;
    addr_t      badv;
    logic       r_req;
    addr_t      r_addr;
    logic [7:0] r_length;
    logic       r_rdy;
    logic       ret_valid;
    logic       ret_last;
    word_t      r_data_axi;

    addr_t      cur_pc;                              // request in flight
    logic       cur_unc;
    exc_t       exp_exc;
    logic       no_resp;                             // flushed fetch
    addr_t      pair_addr;
    fetch_t     exp_data;
    addr_t      exp_raddr;
    logic [7:0] exp_len;
    addr_t      exp_badv;
    logic       r_req_q;
    int         req_starts;
    int         starts_at;
    int         cycles;
    int         mismatches;
    int         failures;

    icache_top #(.SETS(SETS)) dut0 (
        .clk(clk), .rst_n(rst_n), .valid(valid), .flush(flush),
        .pc_in(pc_in), .p_addr(p_addr), .uncache(uncache), .tlb_exception(tlb_exception),
        .cacop_en(cacop_en), .cacop_code(cacop_code), .cache_ready(cache_ready),
        .data_valid(data_valid), .cacop_complete(cacop_complete), .r_data(r_data),
        .pc_out(pc_out), .exception(exception), .badv(badv),
        .r_req(r_req), .r_addr(r_addr), .r_length(r_length), .r_rdy(r_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .r_data_axi(r_data_axi)
    );

    icache_mem_model #(.SEED(16'd11878)) mem0 (
        .clk(clk), .r_req(r_req), .r_addr(r_addr), .r_length(r_length),
        .r_rdy(r_rdy), .ret_valid(ret_valid), .ret_last(ret_last), .r_data_axi(r_data_axi)
    );

    always #20 clk = ~clk;

    assign pair_addr = {cur_pc[31:3], 3'b000};
    assign exp_data  = {(pair_addr + 32'd4) ^ MEM_MARK, pair_addr ^ MEM_MARK};
    assign exp_raddr = cur_unc ? pair_addr : {cur_pc[31:6], 6'b000000};
    assign exp_len   = cur_unc ? 8'd1 : 8'd15;
    assign exp_badv  = (exp_exc != EXC_NONE) ? cur_pc : '0;

    assert property (@(negedge clk) disable iff (!rst_n)
                     data_valid && exp_exc == EXC_NONE |-> r_data == exp_data)
        else begin
            mismatches++;
            $display("Mismatch at %0t: r_data is %h, expected %h", $time, r_data, exp_data);
        end

    assert property (@(negedge clk) disable iff (!rst_n) data_valid |-> exception == exp_exc)
        else begin
            mismatches++;
            $display("Mismatch at %0t: exception is %h, expected %h", $time, exception, exp_exc);
        end

    assert property (@(negedge clk) disable iff (!rst_n) data_valid |-> badv == exp_badv)
        else begin
            mismatches++;
            $display("Mismatch at %0t: badv is %h, expected %h", $time, badv, exp_badv);
        end

    assert property (@(negedge clk) disable iff (!rst_n) data_valid |-> pc_out == cur_pc)
        else begin
            mismatches++;
            $display("Mismatch at %0t: pc_out is %h, expected %h", $time, pc_out, cur_pc);
        end

    assert property (@(negedge clk) disable iff (!rst_n) r_req |-> r_length == exp_len)
        else begin
            mismatches++;
            $display("Mismatch at %0t: r_length is %0d, expected %0d", $time, r_length, exp_len);
        end

    assert property (@(negedge clk) disable iff (!rst_n) r_req |-> r_addr == exp_raddr)
        else begin
            mismatches++;
            $display("Mismatch at %0t: r_addr is %h, expected %h", $time, r_addr, exp_raddr);
        end

    // ready again with the response, held low while memory is requested
    assert property (@(negedge clk) disable iff (!rst_n)
                     data_valid || r_req |-> cache_ready == data_valid)
        else begin
            mismatches++;
            $display("Mismatch at %0t: cache_ready is %b, expected %b",
                     $time, cache_ready, data_valid);
        end

    assert property (@(negedge clk) disable iff (!rst_n) data_valid |-> !no_resp)
        else begin
            failures++;
            $display("data_valid raised at %0t for the flushed fetch at %h", $time, cur_pc);
        end

    // counts memory requests by their first cycle
    always @(negedge clk) begin
        if (r_req && !r_req_q) begin
            req_starts++;
        end
        r_req_q = r_req;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles waiting for the cache", cycles);
            $display("closing: %0d mismatches, %0d other errors", mismatches, failures + 1);
            $display("test failed");
            $finish;
        end
    end

    // drives one request and returns after the edge that accepts it
    task automatic issue(input addr_t pc, input logic unc, input exc_t tlb,
                         input logic op, input cacop_t code);
        @(posedge clk);
        #2;
        cur_pc        = pc;
        cur_unc       = unc;
        exp_exc       = op ? EXC_NONE : ((pc[1:0] != 2'b00) ? EXC_ADEF : tlb);
        valid         = !op;
        cacop_en      = op;
        cacop_code    = code;
        pc_in         = pc;
        p_addr        = pc;
        uncache       = unc;
        tlb_exception = tlb;
        @(negedge clk);
        while (!cache_ready) @(negedge clk);
        @(posedge clk);
        #2;
        valid     = 1'b0;
        cacop_en  = 1'b0;
        starts_at = req_starts;
    endtask

    task automatic fetch(input addr_t pc, input logic unc, input exc_t tlb, input bit miss);
        int waited;
        issue(pc, unc, tlb, 1'b0, '0);
        waited = 0;
        @(negedge clk);
        while (!data_valid) begin
            waited++;
            @(negedge clk);
        end
        assert (miss || waited == 0) else begin
            failures++;
            $display("fetch at %h answered %0d cycles late for a hit", pc, waited);
        end
        @(posedge clk);
        #2;
        assert (req_starts - starts_at == (miss ? 1 : 0)) else begin
            failures++;
            $display("fetch at %h made %0d memory requests, expected %0d",
                     pc, req_starts - starts_at, miss ? 1 : 0);
        end
    endtask

    task automatic cache_op(input addr_t addr, input cacop_t code);
        int waited;
        issue(addr, 1'b0, EXC_NONE, 1'b1, code);
        waited = 0;
        @(negedge clk);
        while (!cacop_complete) begin
            waited++;
            @(negedge clk);
        end
        assert (waited == 1) else begin
            failures++;
            $display("cache operation at %h completed %0d cycles after acceptance",
                     addr, waited + 1);
        end
        @(posedge clk);
        #2;
        assert (req_starts == starts_at) else begin
            failures++;
            $display("cache operation at %h made a memory request", addr);
        end
    endtask

    task automatic fetch_flushed(input addr_t pc);
        issue(pc, 1'b0, EXC_NONE, 1'b0, '0);
        no_resp = 1'b1;
        @(negedge clk);
        while (!r_req) @(negedge clk);
        @(posedge clk);
        #2;
        flush = 1'b1;                                // refill is outstanding here
        @(posedge clk);
        #2;
        flush = 1'b0;
        @(negedge clk);
        while (!cache_ready) @(negedge clk);
        @(posedge clk);
        #2;
        no_resp = 1'b0;
        assert (req_starts - starts_at == 1) else begin
            failures++;
            $display("flushed fetch at %h made %0d memory requests", pc, req_starts - starts_at);
        end
    endtask

    initial begin
        int sweep_wait;
        clk           = 1'b0;
        rst_n         = 1'b0;
        valid         = 1'b0;
        flush         = 1'b0;
        pc_in         = '0;
        p_addr        = '0;
        uncache       = 1'b0;
        tlb_exception = EXC_NONE;
        cacop_en      = 1'b0;
        cacop_code    = '0;
        cur_pc        = '0;
        cur_unc       = 1'b0;
        exp_exc       = EXC_NONE;
        no_resp       = 1'b0;
        r_req_q       = 1'b0;
        req_starts    = 0;
        starts_at     = 0;
        cycles        = 0;
        mismatches    = 0;
        failures      = 0;
        sweep_wait    = 0;

        repeat (9) @(posedge clk);
        @(negedge clk);
        assert (!r_req && !data_valid && !cacop_complete) else begin
            failures++;
            $display("request or response strobe high during reset");
        end
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        while (!cache_ready) begin
            sweep_wait++;
            @(negedge clk);
        end
        assert (sweep_wait >= SETS) else begin
            failures++;
            $display("cache_ready rose %0d cycles after reset, before the valid sweep", sweep_wait);
        end

        // miss fills the line, then a hit in the same line
        fetch(32'h0001_0088, 1'b0, EXC_NONE, 1'b1);
        fetch(32'h0001_00B0, 1'b0, EXC_NONE, 1'b0);

        // uncached fetches go to memory every time
        fetch(32'h0002_00D0, 1'b1, EXC_NONE, 1'b1);
        fetch(32'h0002_00D0, 1'b1, EXC_NONE, 1'b1);

        // misaligned pc and a translation fault
        fetch(32'h0003_0106, 1'b0, EXC_NONE, 1'b0);
        fetch(32'h0003_0108, 1'b0, 7'h03, 1'b0);

        fetch(32'h0004_0140, 1'b0, EXC_NONE, 1'b1);
        fetch(32'h0004_0148, 1'b0, EXC_NONE, 1'b0);
        cache_op(32'h0004_0140, CACOP_HIT_INV);
        fetch(32'h0004_0150, 1'b0, EXC_NONE, 1'b1);

        fetch(32'h0004_8180, 1'b0, EXC_NONE, 1'b1);
        fetch(32'h0004_8188, 1'b0, EXC_NONE, 1'b0);
        for (int w = 0; w < 4; w++) begin
            cache_op(32'h0004_8180 | w, CACOP_INDEX_INV);  // way number in addr[1:0]
        end
        fetch(32'h0004_8190, 1'b0, EXC_NONE, 1'b1);

        // five tags in one set with the first fill oldest
        for (int k = 0; k < 5; k++) begin
            fetch(SET8_BASE + (addr_t'(k) << 12), 1'b0, EXC_NONE, 1'b1);
        end
        for (int k = 1; k < 5; k++) begin
            fetch(SET8_BASE + (addr_t'(k) << 12) + 32'd8, 1'b0, EXC_NONE, 1'b0);
        end
        fetch(SET8_BASE, 1'b0, EXC_NONE, 1'b1);

        fetch_flushed(32'h0006_0240);
        fetch(32'h0006_0248, 1'b0, EXC_NONE, 1'b0);

        $display("closing: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
